// ==== dv/fc_subsystem_tb.sv ====
/*
 * Testbench for the fabric controller. The core side is driven from stimulus
 * tables, and four memory ports answer with rdata = addr XOR a port pattern.
 * Grants are random, so a request may wait several cycles.
 */

`timescale 1ns/1ps

`include "fc_consts.svh"

// One memory port, grants at random and answers one cycle after the grant
module mem_port_model
    import fc_pkg::*;
#(
    parameter logic [31:0] XOR_PAT = 32'h0
) (
    input  logic     clk_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o
);

    logic                  granted_q;
    logic [`FC_ADDR_W-1:0] addr_q;

    initial begin
        rsp_o     = '0;
        granted_q = 1'b0;
        addr_q    = '0;
    end

    always @(posedge clk_i) begin
        granted_q <= req_i.req & rsp_o.gnt;
        addr_q    <= req_i.addr;
    end

    // About one cycle in four has gnt low
    always @(negedge clk_i) begin
        rsp_o.gnt    <= ($urandom % 4) != 0;
        rsp_o.rvalid <= granted_q;
        rsp_o.rdata  <= granted_q ? (addr_q ^ XOR_PAT) : $urandom;
    end

endmodule

module fc_subsystem_tb
    import fc_pkg::*;
();

    localparam logic [31:0] L2_PAT  = 32'h1111_0000;
    localparam logic [31:0] SCM_PAT = 32'h0000_2222;
    localparam int ROUTE_N = 10;
    localparam int APB_N   = 10;
    localparam int IRQ_N   = 3;
    localparam int CYCLE_LIMIT = (ROUTE_N + APB_N + IRQ_N) * 20 + 100;

    // Expected port in scm, set for the scratch window and its alias
    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic        scm;
    } route_vec_t;

    // data holds the write data or the expected read data
    typedef struct packed {
        logic        wr;
        logic [11:0] addr;
        logic [31:0] data;
        logic        err;
    } apb_vec_t;

    typedef struct packed {
        logic [31:0] mask;
        logic [31:0] events;
        logic [31:0] clr;
    } irq_case_t;

    route_vec_t route_tab [ROUTE_N] = '{
        '{32'h1AFF_FFFC, 1'b0, 1'b0},
        '{32'h1B00_0000, 1'b1, 1'b1},
        '{32'h1B00_7FFC, 1'b0, 1'b1},
        '{32'h1B00_8000, 1'b1, 1'b0},
        '{32'h1BFF_FFFC, 1'b0, 1'b0},
        '{32'h1C00_0000, 1'b0, 1'b1},
        '{32'h1C00_7FFC, 1'b1, 1'b1},
        '{32'h1C00_8000, 1'b0, 1'b0},
        '{32'h1C00_4A10, 1'b1, 1'b1},
        '{32'h0000_1000, 1'b0, 1'b0}
    };

    apb_vec_t apb_tab [APB_N] = '{
        '{1'b1, `FC_REG_MASK,    32'hA5A5_0F0F, 1'b0},
        '{1'b0, `FC_REG_MASK,    32'hA5A5_0F0F, 1'b0},
        '{1'b0, `FC_REG_PENDING, 32'h0000_0000, 1'b0},
        '{1'b1, `FC_REG_FETCH,   32'h0000_0001, 1'b0},
        '{1'b0, `FC_REG_FETCH,   32'h0000_0001, 1'b0},
        '{1'b1, `FC_REG_CLEAR,   32'h0000_00FF, 1'b0},
        '{1'b0, `FC_REG_CLEAR,   32'h0000_0000, 1'b0},
        '{1'b0, `FC_REG_EVT_ID,  32'h0000_0000, 1'b0},
        '{1'b0, 12'h014,         32'h0000_0000, 1'b1},
        '{1'b1, 12'h100,         32'h1234_5678, 1'b1}
    };

    irq_case_t irq_tab [IRQ_N] = '{
        '{32'hFFFF_FFFF, 32'h8000_0011, 32'h0000_0000},
        '{32'h0000_00F0, 32'h0000_8130, 32'h0000_8001},
        '{32'h0F00_0000, 32'h4A00_0200, 32'h0000_0200}
    };

    logic     clk = 1'b0;
    logic     rst_n;
    logic     fetch_en;
    bus_req_t instr_req;
    bus_req_t data_req;
    bus_rsp_t instr_rsp;
    bus_rsp_t data_rsp;
    bus_req_t l2_instr_req;
    bus_req_t scm_instr_req;
    bus_req_t l2_data_req;
    bus_req_t scm_data_req;
    bus_rsp_t l2_instr_rsp;
    bus_rsp_t scm_instr_rsp;
    bus_rsp_t l2_data_rsp;
    bus_rsp_t scm_data_rsp;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    irq_vec_t events;
    logic     fifo_valid;
    evt_id_t  fifo_data;
    logic     fifo_fulln;
    logic     irq_ack;
    irq_id_t  irq_ack_id;
    logic     irq_req;
    irq_id_t  irq_id;
    logic     fetch_en_out;
    int       errors = 0;
    int       checks = 0;
    int       cycles = 0;

    always #4 clk = ~clk;

    fc_subsystem uut (
        .clk_i              ( clk           ),
        .rst_n_i            ( rst_n         ),
        .fetch_en_i         ( fetch_en      ),
        .instr_req_i        ( instr_req     ),
        .instr_rsp_o        ( instr_rsp     ),
        .data_req_i         ( data_req      ),
        .data_rsp_o         ( data_rsp      ),
        .l2_instr_req_o     ( l2_instr_req  ),
        .l2_instr_rsp_i     ( l2_instr_rsp  ),
        .scm_instr_req_o    ( scm_instr_req ),
        .scm_instr_rsp_i    ( scm_instr_rsp ),
        .l2_data_req_o      ( l2_data_req   ),
        .l2_data_rsp_i      ( l2_data_rsp   ),
        .scm_data_req_o     ( scm_data_req  ),
        .scm_data_rsp_i     ( scm_data_rsp  ),
        .apb_req_i          ( apb_req       ),
        .apb_rsp_o          ( apb_rsp       ),
        .events_i           ( events        ),
        .event_fifo_valid_i ( fifo_valid    ),
        .event_fifo_data_i  ( fifo_data     ),
        .event_fifo_fulln_o ( fifo_fulln    ),
        .irq_ack_i          ( irq_ack       ),
        .irq_ack_id_i       ( irq_ack_id    ),
        .irq_req_o          ( irq_req       ),
        .irq_id_o           ( irq_id        ),
        .fetch_en_o         ( fetch_en_out  )
    );

    mem_port_model #(.XOR_PAT(L2_PAT)) l2_instr_mem (
        .clk_i(clk), .req_i(l2_instr_req), .rsp_o(l2_instr_rsp));
    mem_port_model #(.XOR_PAT(SCM_PAT)) scm_instr_mem (
        .clk_i(clk), .req_i(scm_instr_req), .rsp_o(scm_instr_rsp));
    mem_port_model #(.XOR_PAT(L2_PAT)) l2_data_mem (
        .clk_i(clk), .req_i(l2_data_req), .rsp_o(l2_data_rsp));
    mem_port_model #(.XOR_PAT(SCM_PAT)) scm_data_mem (
        .clk_i(clk), .req_i(scm_data_req), .rsp_o(scm_data_rsp));

    // **********************************************************
    // Checking helpers
    // **********************************************************

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("Fail %s: expected 0x%08h, got 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    function automatic int top_line(input logic [31:0] vec);
        for (int i = 31; i >= 0; i--) begin
            if (vec[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    // Run guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            $display("Run timed out after %0d cycles, errors: %0d", cycles, errors);
            $display("sim failed");
            $finish;
        end
    end

    // **********************************************************
    // Core bus side
    // **********************************************************

    // Walks the route table from offs, next request goes out right after a grant
    task automatic drive_bus(input logic bus, input int offs);
        int          n_sent;
        int          n_done;
        route_vec_t  v;
        bus_req_t    r;
        bus_rsp_t    rsp;
        bus_req_t    l2_seen;
        bus_req_t    scm_seen;
        bus_req_t    port;
        logic        scm;
        string       pfx;
        logic [31:0] exp_q [$];
        n_sent = 0;
        n_done = 0;
        r      = '0;
        v      = '0;
        pfx    = bus ? "data " : "instr ";
        while (n_done < ROUTE_N) begin
            @(negedge clk);
            if (!r.req && (n_sent < ROUTE_N)) begin
                v = route_tab[(n_sent + offs) % ROUTE_N];
                r = '{1'b1, v.addr, v.we, 4'hF, $urandom};
            end
            if (bus) begin
                data_req = r;
            end else begin
                instr_req = r;
            end
            @(posedge clk);
            rsp      = bus ? data_rsp : instr_rsp;
            l2_seen  = bus ? l2_data_req : l2_instr_req;
            scm_seen = bus ? scm_data_req : scm_instr_req;
            if (rsp.rvalid) begin
                if (exp_q.size() == 0) begin
                    $display("The %sbus returned a response with no request waiting", pfx);
                    errors++;
                end else begin
                    check({pfx, "rdata"}, exp_q.pop_front(), rsp.rdata);
                end
                n_done++;
            end
            if (r.req && rsp.gnt) begin
                scm  = v.scm;
                port = scm ? scm_seen : l2_seen;
                check({pfx, "l2 req"}, !scm, l2_seen.req);
                check({pfx, "scm req"}, scm, scm_seen.req);
                check({pfx, "port addr"}, r.addr, port.addr);
                check({pfx, "port we"}, r.we, port.we);
                check({pfx, "port wdata"}, r.wdata, port.wdata);
                exp_q.push_back(r.addr ^ (scm ? SCM_PAT : L2_PAT));
                n_sent++;
                r = '0;
            end
        end
    endtask

    // **********************************************************
    // APB and event unit
    // **********************************************************

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
        @(negedge clk);
        apb_req = '{1'b1, 1'b0, wr, addr, wdata};
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        rdata = apb_rsp.prdata;
        check("pready", 1'b1, apb_rsp.pready);
        check("pslverr", exp_err, apb_rsp.pslverr);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic check_fetch(input logic pin, input logic reg_bit);
        @(negedge clk);
        fetch_en = pin;
        @(posedge clk);
        check("fetch_en_o", pin & reg_bit, fetch_en_out);
    endtask

    task automatic ack_line(input int line);
        irq_ack    = 1'b1;
        irq_ack_id = irq_id_t'(line);
        @(negedge clk);
        irq_ack    = 1'b0;
    endtask

    task automatic run_irq_table();
        irq_case_t   c;
        logic [31:0] expv;
        logic [31:0] rd;
        int          line;
        for (int i = 0; i < IRQ_N; i++) begin
            c = irq_tab[i];
            apb_xfer(1'b1, `FC_REG_MASK, c.mask, 1'b0, rd);
            events = c.events;
            @(negedge clk);
            events = '0;
            @(negedge clk);
            expv = c.events & c.mask;
            // Highest enabled line first, then each lower one after its ack
            while (expv != 0) begin
                line = top_line(expv);
                check("irq_req_o", 1'b1, irq_req);
                check("irq_id_o", line, irq_id);
                ack_line(line);
                expv[line] = 1'b0;
                @(negedge clk);
            end
            check("irq_req_o", 1'b0, irq_req);
            apb_xfer(1'b0, `FC_REG_PENDING, '0, 1'b0, rd);
            check("PENDING", c.events & ~c.mask, rd);
            apb_xfer(1'b1, `FC_REG_CLEAR, c.clr, 1'b0, rd);
            apb_xfer(1'b0, `FC_REG_PENDING, '0, 1'b0, rd);
            check("PENDING after clear", c.events & ~c.mask & ~c.clr, rd);
            apb_xfer(1'b1, `FC_REG_CLEAR, 32'hFFFF_FFFF, 1'b0, rd);
        end
    endtask

    task automatic run_fifo();
        logic [31:0] rd;
        apb_xfer(1'b1, `FC_REG_MASK, 32'h1 << `FC_FIFO_IRQ, 1'b0, rd);
        check("event_fifo_fulln_o", 1'b1, fifo_fulln);
        fifo_valid = 1'b1;
        fifo_data  = 8'h5A;
        @(negedge clk);
        check("event_fifo_fulln_o", 1'b0, fifo_fulln);
        // Second push must bounce off the full holder
        fifo_data  = 8'hC3;
        @(negedge clk);
        fifo_valid = 1'b0;
        check("irq_req_o", 1'b1, irq_req);
        check("irq_id_o", `FC_FIFO_IRQ, irq_id);
        apb_xfer(1'b0, `FC_REG_EVT_ID, '0, 1'b0, rd);
        check("EVT_ID", 32'h0000_005A, rd);
        check("event_fifo_fulln_o", 1'b0, fifo_fulln);
        ack_line(`FC_FIFO_IRQ);
        check("event_fifo_fulln_o", 1'b1, fifo_fulln);
        @(negedge clk);
        check("irq_req_o", 1'b0, irq_req);
        apb_xfer(1'b0, `FC_REG_PENDING, '0, 1'b0, rd);
        check("PENDING", 32'h0, rd);
    endtask

    // **********************************************************
    // Main sequence
    // **********************************************************

    initial begin
        apb_vec_t    a;
        logic [31:0] rd;
        void'($urandom(32'hab1aa8d2));
        rst_n      = 1'b0;
        fetch_en   = 1'b1;
        instr_req  = '0;
        data_req   = '0;
        apb_req    = '0;
        events     = '0;
        fifo_valid = 1'b0;
        fifo_data  = '0;
        irq_ack    = 1'b0;
        irq_ack_id = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check("irq_req_o", 1'b0, irq_req);
        check("irq_id_o", 1'b0, irq_id);
        check("fetch_en_o", 1'b0, fetch_en_out);
        check("event_fifo_fulln_o", 1'b1, fifo_fulln);
        check("l2_instr_req_o.req", 1'b0, l2_instr_req.req);
        check("scm_instr_req_o.req", 1'b0, scm_instr_req.req);
        check("l2_data_req_o.req", 1'b0, l2_data_req.req);
        check("scm_data_req_o.req", 1'b0, scm_data_req.req);

        // Both buses at once, each from its own place in the table
        fork
            drive_bus(1'b0, 0);
            drive_bus(1'b1, ROUTE_N / 2);
        join

        for (int i = 0; i < APB_N; i++) begin
            a = apb_tab[i];
            apb_xfer(a.wr, a.addr, a.data, a.err, rd);
            if (!a.wr && !a.err) begin
                check("prdata", a.data, rd);
            end
        end
        check_fetch(1'b1, 1'b1);
        check_fetch(1'b0, 1'b1);
        fetch_en = 1'b1;
        apb_xfer(1'b1, `FC_REG_FETCH, 32'h0, 1'b0, rd);
        check_fetch(1'b1, 1'b0);

        run_irq_table();
        run_fifo();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== hdl/event_apb_regs.sv ====
/*
 * APB register file of the event unit, zero wait states.
 * PENDING and EVT_ID are read-only, CLEAR reads as zero. A CLEAR write
 * clears pending bits at the edge that ends the access phase.
 */

`timescale 1ns/1ps

`include "fc_consts.svh"

module event_apb_regs
    import fc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,
    input  irq_vec_t pending_i,
    input  evt_id_t  evt_id_i,
    output irq_vec_t mask_o,
    output irq_vec_t clear_o,
    output logic     fetch_o
);

    logic     access;
    logic     wr;
    logic     mapped;
    irq_vec_t mask_q;
    logic     fetch_q;

    assign access = apb_req_i.psel & apb_req_i.penable;
    assign wr     = access & apb_req_i.pwrite;

    // **********************************************************
    // Write side
    // **********************************************************

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mask_q  <= '0;
            fetch_q <= 1'b0;
        end else if (wr) begin
            if (apb_req_i.paddr == `FC_REG_MASK) begin
                mask_q <= apb_req_i.pwdata;
            end
            if (apb_req_i.paddr == `FC_REG_FETCH) begin
                fetch_q <= apb_req_i.pwdata[0];
            end
        end
    end

    // Clear pulse lasts the single access cycle
    assign clear_o = (wr && (apb_req_i.paddr == `FC_REG_CLEAR)) ? apb_req_i.pwdata : '0;

    // **********************************************************
    // Read side
    // **********************************************************

    always_comb begin
        apb_rsp_o.prdata = '0;
        mapped           = 1'b1;
        case (apb_req_i.paddr)
            `FC_REG_MASK:    apb_rsp_o.prdata = mask_q;
            `FC_REG_PENDING: apb_rsp_o.prdata = pending_i;
            `FC_REG_CLEAR:   apb_rsp_o.prdata = '0;
            `FC_REG_FETCH:   apb_rsp_o.prdata[0] = fetch_q;
            `FC_REG_EVT_ID:  apb_rsp_o.prdata[`FC_EVT_ID_W-1:0] = evt_id_i;
            default:         mapped = 1'b0;
        endcase
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = access & ~mapped;
    end

    assign mask_o  = mask_q;
    assign fetch_o = fetch_q;

endmodule

// ==== hdl/event_fifo_decoder.sv ====
/*
 * One-deep event ID holder standing in for the event FIFO.
 * A push is ignored while the holder is full. It is released when the
 * FIFO interrupt line is cleared by acknowledge or by register.
 */

`timescale 1ns/1ps

`include "fc_consts.svh"

module event_fifo_decoder
    import fc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  irq_vec_t events_i,
    input  logic     evt_valid_i,
    input  evt_id_t  evt_data_i,
    output logic     evt_fulln_o,
    input  logic     fifo_release_i,
    output irq_vec_t line_set_o,
    output evt_id_t  evt_id_o
);

    logic    full_q;
    logic    push;
    evt_id_t id_q;

    assign push = evt_valid_i & ~full_q;

    // A push in the release cycle keeps the holder full
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
            id_q   <= '0;
        end else if (push) begin
            full_q <= 1'b1;
            id_q   <= evt_data_i;
        end else if (fifo_release_i) begin
            full_q <= 1'b0;
        end
    end

    always_comb begin
        line_set_o = events_i;
        if (push) begin
            line_set_o[`FC_FIFO_IRQ] = 1'b1;
        end
    end

    assign evt_fulln_o = ~full_q;
    assign evt_id_o    = id_q;

endmodule

// ==== hdl/fc_bus_demux.sv ====
/*
 * Steers one core bus to the L2 or the scratch port by address.
 * Request and grant paths are combinational. The response is taken one
 * cycle after the grant from the port recorded at that grant.
 */

`timescale 1ns/1ps

`include "fc_consts.svh"

module fc_bus_demux
    import fc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  bus_req_t core_req_i,
    output bus_rsp_t core_rsp_o,
    output bus_req_t l2_req_o,
    input  bus_rsp_t l2_rsp_i,
    output bus_req_t scm_req_o,
    input  bus_rsp_t scm_rsp_i
);

    logic is_scm;
    logic gnt;
    logic rsp_scm_q;

    // Either the scratch window or its alias
    assign is_scm = ((core_req_i.addr >= `FC_SCM_START) &&
                     (core_req_i.addr <  `FC_SCM_END)) ||
                    ((core_req_i.addr >= `FC_SCM_ALIAS_START) &&
                     (core_req_i.addr <  `FC_SCM_ALIAS_END));

    // Only the chosen port sees req, the other fields go to both
    always_comb begin
        l2_req_o      = core_req_i;
        scm_req_o     = core_req_i;
        l2_req_o.req  = core_req_i.req & ~is_scm;
        scm_req_o.req = core_req_i.req &  is_scm;
    end

    assign gnt = is_scm ? scm_rsp_i.gnt : l2_rsp_i.gnt;

    // Remember which port granted, nothing is recorded under back-pressure
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_scm_q <= 1'b0;
        end else if (core_req_i.req && gnt) begin
            rsp_scm_q <= is_scm;
        end
    end

    always_comb begin
        core_rsp_o.gnt = gnt;
        if (rsp_scm_q) begin
            core_rsp_o.rvalid = scm_rsp_i.rvalid;
            core_rsp_o.rdata  = scm_rsp_i.rdata;
        end else begin
            core_rsp_o.rvalid = l2_rsp_i.rvalid;
            core_rsp_o.rdata  = l2_rsp_i.rdata;
        end
    end

endmodule

// ==== hdl/fc_consts.svh ====
/*
 * Widths, scratch-memory windows and event unit register map.
 * Window END addresses are exclusive. Register offsets are byte offsets
 * decoded on the full APB address, so unaligned accesses are unmapped.
 */

`ifndef FC_CONSTS_SVH
`define FC_CONSTS_SVH

// Core bus
`define FC_ADDR_W           32
`define FC_DATA_W           32
`define FC_BE_W             4

// Private scratch window and its alias
`define FC_SCM_START        32'h1B00_0000
`define FC_SCM_END          32'h1B00_8000
`define FC_SCM_ALIAS_START  32'h1C00_0000
`define FC_SCM_ALIAS_END    32'h1C00_8000

// Event unit
`define FC_NB_IRQ           32
`define FC_IRQ_ID_W         5
`define FC_EVT_ID_W         8
`define FC_FIFO_IRQ         26

// APB register map
`define FC_APB_ADDR_W       12
`define FC_REG_MASK         12'h000
`define FC_REG_PENDING      12'h004
`define FC_REG_CLEAR        12'h008
`define FC_REG_FETCH        12'h00C
`define FC_REG_EVT_ID       12'h010

`endif

// ==== hdl/fc_pkg.sv ====
/*
 * Bus, APB and interrupt types shared by the fabric controller.
 * Field widths come from the constants header.
 */

`include "fc_consts.svh"

package fc_pkg;

    // Core memory request, held by the core until gnt
    typedef struct packed {
        logic                   req;
        logic [`FC_ADDR_W-1:0]  addr;
        logic                   we;
        logic [`FC_BE_W-1:0]    be;
        logic [`FC_DATA_W-1:0]  wdata;
    } bus_req_t;

    // Grant and the response one cycle later
    typedef struct packed {
        logic                   gnt;
        logic                   rvalid;
        logic [`FC_DATA_W-1:0]  rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`FC_APB_ADDR_W-1:0]  paddr;
        logic [`FC_DATA_W-1:0]      pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`FC_DATA_W-1:0]  prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // One bit per interrupt line
    typedef logic [`FC_NB_IRQ-1:0]   irq_vec_t;
    typedef logic [`FC_IRQ_ID_W-1:0] irq_id_t;
    typedef logic [`FC_EVT_ID_W-1:0] evt_id_t;

endpackage

// ==== hdl/fc_subsystem.sv ====
/*
 * Fabric controller without the core: instruction and data bus routing
 * plus the event and interrupt unit. The core is external and connects
 * to the instr, data and irq ports. The event FIFO is one entry deep.
 */

`timescale 1ns/1ps

`include "fc_consts.svh"

module fc_subsystem
    import fc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     fetch_en_i,

    input  bus_req_t instr_req_i,
    output bus_rsp_t instr_rsp_o,
    input  bus_req_t data_req_i,
    output bus_rsp_t data_rsp_o,

    output bus_req_t l2_instr_req_o,
    input  bus_rsp_t l2_instr_rsp_i,
    output bus_req_t scm_instr_req_o,
    input  bus_rsp_t scm_instr_rsp_i,
    output bus_req_t l2_data_req_o,
    input  bus_rsp_t l2_data_rsp_i,
    output bus_req_t scm_data_req_o,
    input  bus_rsp_t scm_data_rsp_i,

    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,

    input  irq_vec_t events_i,
    input  logic     event_fifo_valid_i,
    input  evt_id_t  event_fifo_data_i,
    output logic     event_fifo_fulln_o,

    input  logic     irq_ack_i,
    input  irq_id_t  irq_ack_id_i,
    output logic     irq_req_o,
    output irq_id_t  irq_id_o,
    output logic     fetch_en_o
);

    irq_vec_t line_set;
    irq_vec_t pending;
    irq_vec_t mask;
    irq_vec_t ack_vec;
    irq_vec_t reg_clear;
    irq_vec_t line_clr;
    evt_id_t  evt_id;
    logic     fetch_reg;

    // **********************************************************
    // Core bus routing, L2 or scratch
    // **********************************************************

    fc_bus_demux i_instr_demux (
        .clk_i      ( clk_i           ),
        .rst_n_i    ( rst_n_i         ),
        .core_req_i ( instr_req_i     ),
        .core_rsp_o ( instr_rsp_o     ),
        .l2_req_o   ( l2_instr_req_o  ),
        .l2_rsp_i   ( l2_instr_rsp_i  ),
        .scm_req_o  ( scm_instr_req_o ),
        .scm_rsp_i  ( scm_instr_rsp_i )
    );

    fc_bus_demux i_data_demux (
        .clk_i      ( clk_i          ),
        .rst_n_i    ( rst_n_i        ),
        .core_req_i ( data_req_i     ),
        .core_rsp_o ( data_rsp_o     ),
        .l2_req_o   ( l2_data_req_o  ),
        .l2_rsp_i   ( l2_data_rsp_i  ),
        .scm_req_o  ( scm_data_req_o ),
        .scm_rsp_i  ( scm_data_rsp_i )
    );

    // **********************************************************
    // Event unit
    // **********************************************************

    // Acknowledge and register clear both drop a line
    assign line_clr = ack_vec | reg_clear;

    event_fifo_decoder i_evt_dec (
        .clk_i          ( clk_i                   ),
        .rst_n_i        ( rst_n_i                 ),
        .events_i       ( events_i                ),
        .evt_valid_i    ( event_fifo_valid_i      ),
        .evt_data_i     ( event_fifo_data_i       ),
        .evt_fulln_o    ( event_fifo_fulln_o      ),
        .fifo_release_i ( line_clr[`FC_FIFO_IRQ]  ),
        .line_set_o     ( line_set                ),
        .evt_id_o       ( evt_id                  )
    );

    for (genvar i = 0; i < `FC_NB_IRQ; i++) begin : g_irq_line
        irq_line i_line (
            .clk_i     ( clk_i       ),
            .rst_n_i   ( rst_n_i     ),
            .set_i     ( line_set[i] ),
            .clr_i     ( line_clr[i] ),
            .pending_o ( pending[i]  )
        );
    end

    irq_arbiter i_arbiter (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .pending_i    ( pending      ),
        .mask_i       ( mask         ),
        .irq_ack_i    ( irq_ack_i    ),
        .irq_ack_id_i ( irq_ack_id_i ),
        .irq_req_o    ( irq_req_o    ),
        .irq_id_o     ( irq_id_o     ),
        .ack_vec_o    ( ack_vec      )
    );

    event_apb_regs i_regs (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .apb_req_i ( apb_req_i ),
        .apb_rsp_o ( apb_rsp_o ),
        .pending_i ( pending   ),
        .evt_id_i  ( evt_id    ),
        .mask_o    ( mask      ),
        .clear_o   ( reg_clear ),
        .fetch_o   ( fetch_reg )
    );

    // Core fetches only when both software and the pin allow it
    assign fetch_en_o = fetch_reg & fetch_en_i;

endmodule

// ==== hdl/irq_arbiter.sv ====
/*
 * Fixed priority, the highest-numbered enabled pending line wins.
 * The choice is registered, so the core sees it one cycle after the
 * pending bit. Acknowledges are decoded to one line without checking.
 */

`timescale 1ns/1ps

`include "fc_consts.svh"

module irq_arbiter
    import fc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  irq_vec_t pending_i,
    input  irq_vec_t mask_i,
    input  logic     irq_ack_i,
    input  irq_id_t  irq_ack_id_i,
    output logic     irq_req_o,
    output irq_id_t  irq_id_o,
    output irq_vec_t ack_vec_o
);

    irq_vec_t masked;
    logic     any_c;
    irq_id_t  id_c;
    logic     irq_req_q;
    irq_id_t  irq_id_q;

    assign masked = pending_i & mask_i;

    // Ascending scan, the last set line is the highest one
    always_comb begin
        any_c = 1'b0;
        id_c  = '0;
        for (int i = 0; i < `FC_NB_IRQ; i++) begin
            if (masked[i]) begin
                any_c = 1'b1;
                id_c  = irq_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_req_q <= 1'b0;
            irq_id_q  <= '0;
        end else begin
            irq_req_q <= any_c;
            irq_id_q  <= id_c;
        end
    end

    always_comb begin
        ack_vec_o = '0;
        if (irq_ack_i) begin
            ack_vec_o[irq_ack_id_i] = 1'b1;
        end
    end

    assign irq_req_o = irq_req_q;
    assign irq_id_o  = irq_id_q;

endmodule

// ==== hdl/irq_line.sv ====
/*
 * Pending flag of one interrupt line.
 * A set in the same cycle as a clear wins, so no event is lost.
 */

`timescale 1ns/1ps

module irq_line (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic set_i,
    input  logic clr_i,
    output logic pending_o
);

    logic pending_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (set_i) begin
            pending_q <= 1'b1;
        end else if (clr_i) begin
            pending_q <= 1'b0;
        end
    end

    assign pending_o = pending_q;

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/fc_pkg.sv
hdl/fc_bus_demux.sv
hdl/event_fifo_decoder.sv
hdl/irq_line.sv
hdl/irq_arbiter.sv
hdl/event_apb_regs.sv
hdl/fc_subsystem.sv
dv/fc_subsystem_tb.sv
